/* hw/mem_pkg.sv */
package mem_pkg;

	//////////////////////////////
	// Bus types
	//////////////////////////////

	// CPU word address
	typedef logic [15:0] mem_addr_t;

	// Data word on the memory bus
	typedef logic [15:0] mem_word_t;

	// CPU request held stable until work_done
	typedef struct packed {
		logic      rd;
		logic      wr;
		logic      init_wr;
		mem_addr_t addr;
		mem_word_t wdata;
	} mem_req_t;

	// Response of one RAM bank
	typedef struct packed {
		logic      done;
		mem_word_t rdata;
	} ram_rsp_t;

	//////////////////////////////
	// Fixed addresses and words
	//////////////////////////////

	// UART status register
	localparam mem_addr_t MEM_STATUS_ADDR = 16'hBF01;

	// Upper bits of the status word
	localparam logic [13:0] STATUS_FILL = '1;

endpackage

/* hw/ram_port.sv */
`timescale 1ns/100ps

module ram_port import mem_pkg::*; #(
	parameter int ADDR_BITS   = 8,
	parameter int WAIT_CYCLES = 0
) (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     need_to_work,
	input  mem_req_t req,
	output ram_rsp_t rsp
);

	localparam int DEPTH = 2 ** ADDR_BITS;
	// Wide enough to hold WAIT_CYCLES, one bit at least
	localparam int CNT_W = $clog2(WAIT_CYCLES + 2);

	mem_word_t            mem [DEPTH];
	logic [ADDR_BITS-1:0] word_addr;
	logic                 is_write;
	logic                 busy_q;
	logic [CNT_W-1:0]     cnt_q;
	logic                 last_cycle;
	logic                 finish;
	logic                 done_q;
	mem_word_t            rdata_q;

	// Bank is addressed by the low address bits only
	assign word_addr = req.addr[ADDR_BITS-1:0];

	// Initial load behaves as a plain write
	assign is_write = req.wr | req.init_wr;

	//////////////////////////////
	// Wait-state counter
	//////////////////////////////

	// Last wait cycle of the access
	assign last_cycle = busy_q ? (cnt_q == CNT_W'(1)) : (WAIT_CYCLES == 0);

	// Edge on which the access completes
	assign finish = need_to_work & ~done_q & last_cycle;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy_q <= 1'b0;
			cnt_q  <= '0;
			done_q <= 1'b0;
		end else if (done_q) begin
			// Done is a single-cycle pulse
			done_q <= 1'b0;
			busy_q <= 1'b0;
			cnt_q  <= '0;
		end else if (finish) begin
			done_q <= 1'b1;
			busy_q <= 1'b0;
			cnt_q  <= '0;
		end else if (need_to_work) begin
			if (!busy_q) begin
				// First edge of a new access
				busy_q <= 1'b1;
				cnt_q  <= CNT_W'(WAIT_CYCLES);
			end else begin
				cnt_q <= cnt_q - CNT_W'(1);
			end
		end
	end

	//////////////////////////////
	// Word array
	//////////////////////////////

	// Bank starts out cleared
	initial begin
		for (int i = 0; i < DEPTH; i++) begin
			mem[i] = '0;
		end
	end

	// Write and read happen on the completing edge
	always @(posedge clk) begin
		if (finish) begin
			if (is_write) begin
				mem[word_addr] <= req.wdata;
			end
			if (req.rd) begin
				rdata_q <= mem[word_addr];
			end
		end
	end

	assign rsp = '{done: done_q, rdata: rdata_q};

	//////////////////////////////
	// Checks
	//////////////////////////////

	// A done pulse always answers a request
	a_done_needs_request: assert property (
		@(posedge clk) disable iff (!rst_n)
		$rose(done_q) |-> $past(need_to_work)
	) else $error("ram_port: done raised without a request");

	// Request level must not drop while counting
	a_request_held: assert property (
		@(posedge clk) disable iff (!rst_n)
		busy_q |-> need_to_work
	) else $error("ram_port: need_to_work dropped during wait states");

endmodule

/* hw/ram_controller.sv */
`timescale 1ns/100ps

module ram_controller import mem_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  mem_req_t  req,
	input  logic      uart_received_data,
	input  ram_rsp_t  ram1_rsp,
	input  ram_rsp_t  ram2_rsp,
	output logic      ram1_need_to_work,
	output logic      ram2_need_to_work,
	output logic      work_done,
	output mem_word_t feedback
);

	logic      access;
	logic      status_hit;
	logic      sel_ram1;
	logic      sel_ram2;
	logic      ram1_hit;
	logic      ram2_hit;
	mem_word_t status_word;
	logic      result_valid;
	mem_word_t result_word;
	mem_word_t feedback_q;

	//////////////////////////////
	// Address decode
	//////////////////////////////

	assign access = req.rd | req.wr | req.init_wr;

	// Status address wins over both banks
	assign status_hit = access & (req.addr == MEM_STATUS_ADDR);

	// Bit 15 picks the bank
	assign sel_ram1 = access & ~status_hit & req.addr[15];
	assign sel_ram2 = access & ~status_hit & ~req.addr[15];

	// Selected bank finished this cycle
	assign ram1_hit = sel_ram1 & ram1_rsp.done;
	assign ram2_hit = sel_ram2 & ram2_rsp.done;

	//////////////////////////////
	// Bank requests and done
	//////////////////////////////

	// Level drops in the done cycle so the access runs once
	assign ram1_need_to_work = sel_ram1 & ~ram1_rsp.done;
	assign ram2_need_to_work = sel_ram2 & ~ram2_rsp.done;

	// Idle and status accesses complete at once
	assign work_done = ~access | status_hit | ram1_hit | ram2_hit;

	//////////////////////////////
	// Feedback
	//////////////////////////////

	// Bit 1 is the UART receive flag
	assign status_word = {STATUS_FILL, uart_received_data, 1'b1};

	always_comb begin
		result_valid = 1'b0;
		result_word  = feedback_q;
		if (req.rd) begin
			if (status_hit) begin
				result_valid = 1'b1;
				result_word  = status_word;
			end else if (ram1_hit) begin
				result_valid = 1'b1;
				result_word  = ram1_rsp.rdata;
			end else if (ram2_hit) begin
				result_valid = 1'b1;
				result_word  = ram2_rsp.rdata;
			end
		end
	end

	// Keeps the last read result for later cycles
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			feedback_q <= '0;
		end else if (result_valid) begin
			feedback_q <= result_word;
		end
	end

	assign feedback = result_word;

	//////////////////////////////
	// Checks
	//////////////////////////////

	// Only one bank is ever busy
	a_one_bank: assert property (
		@(posedge clk) disable iff (!rst_n)
		!(ram1_need_to_work && ram2_need_to_work)
	) else $error("ram_controller: both banks requested");

	// Status access leaves both banks idle, now and next cycle
	a_status_no_bank: assert property (
		@(posedge clk) disable iff (!rst_n)
		status_hit |-> !(ram1_need_to_work || ram2_need_to_work)
			##1 !(ram1_rsp.done || ram2_rsp.done)
	) else $error("ram_controller: bank activity on status access");

endmodule

/* hw/mem_subsystem.sv */
`timescale 1ns/100ps

module mem_subsystem import mem_pkg::*; #(
	parameter int RAM_ADDR_BITS = 8,
	parameter int RAM1_WAIT     = 2,
	parameter int RAM2_WAIT     = 0
) (
	input  logic      clk,
	input  logic      rst_n,
	input  mem_req_t  req,
	input  logic      uart_received_data,
	output logic      work_done,
	output mem_word_t feedback
);

	logic     ram1_need_to_work;
	logic     ram2_need_to_work;
	ram_rsp_t ram1_rsp;
	ram_rsp_t ram2_rsp;

	//////////////////////////////
	// RAM banks
	//////////////////////////////

	// Bank 1 serves the upper address half
	ram_port #(
		.ADDR_BITS   (RAM_ADDR_BITS),
		.WAIT_CYCLES (RAM1_WAIT)
	) u_ram1 (
		.clk          (clk),
		.rst_n        (rst_n),
		.need_to_work (ram1_need_to_work),
		.req          (req),
		.rsp          (ram1_rsp)
	);

	// Bank 2 serves the lower address half
	ram_port #(
		.ADDR_BITS   (RAM_ADDR_BITS),
		.WAIT_CYCLES (RAM2_WAIT)
	) u_ram2 (
		.clk          (clk),
		.rst_n        (rst_n),
		.need_to_work (ram2_need_to_work),
		.req          (req),
		.rsp          (ram2_rsp)
	);

	//////////////////////////////
	// Controller
	//////////////////////////////

	ram_controller u_ctrl (
		.clk                (clk),
		.rst_n              (rst_n),
		.req                (req),
		.uart_received_data (uart_received_data),
		.ram1_rsp           (ram1_rsp),
		.ram2_rsp           (ram2_rsp),
		.ram1_need_to_work  (ram1_need_to_work),
		.ram2_need_to_work  (ram2_need_to_work),
		.work_done          (work_done),
		.feedback           (feedback)
	);

endmodule

/* sim/tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen (
	output logic clk,
	output logic rst_n
);

	// 100 ns period
	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Reset held low over the first two rising edges
	initial begin
		rst_n = 1'b0;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

/* include/tb_vectors.svh */
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// Columns: name, rd, wr, init_wr, addr, uart flag, check kind,
// expected feedback (CHK_TABLE rows only), expected latency in cycles

localparam int NUM_VECTORS = 20;

localparam vec_t VECTORS [NUM_VECTORS] = '{
	'{"idle_rst", 1'b0, 1'b0, 1'b0, 16'h0000, 1'b0, CHK_TABLE, 16'h0000, LAT_NOW},
	// Bank 1 and bank 2 at the same low bits
	'{"b1_wr_10", 1'b0, 1'b1, 1'b0, 16'h8010, 1'b0, CHK_LAST, 16'h0000, LAT1},
	'{"b1_rd_10", 1'b1, 1'b0, 1'b0, 16'h8010, 1'b0, CHK_SHADOW, 16'h0000, LAT1},
	'{"b2_wr_10", 1'b0, 1'b1, 1'b0, 16'h0010, 1'b0, CHK_LAST, 16'h0000, LAT2},
	'{"b2_rd_10", 1'b1, 1'b0, 1'b0, 16'h0010, 1'b0, CHK_SHADOW, 16'h0000, LAT2},
	'{"b1_again", 1'b1, 1'b0, 1'b0, 16'h8010, 1'b0, CHK_SHADOW, 16'h0000, LAT1},
	// Initial load path
	'{"b1_init ", 1'b0, 1'b0, 1'b1, 16'h80A5, 1'b0, CHK_LAST, 16'h0000, LAT1},
	'{"b2_init ", 1'b0, 1'b0, 1'b1, 16'h00A5, 1'b0, CHK_LAST, 16'h0000, LAT2},
	'{"b1_rdini", 1'b1, 1'b0, 1'b0, 16'h80A5, 1'b0, CHK_SHADOW, 16'h0000, LAT1},
	'{"b2_rdini", 1'b1, 1'b0, 1'b0, 16'h00A5, 1'b0, CHK_SHADOW, 16'h0000, LAT2},
	// Words that share low bits with the status address
	'{"b1_wr_01", 1'b0, 1'b1, 1'b0, 16'h8001, 1'b0, CHK_LAST, 16'h0000, LAT1},
	'{"b2_wr_01", 1'b0, 1'b1, 1'b0, 16'h0001, 1'b0, CHK_LAST, 16'h0000, LAT2},
	'{"st_rd_lo", 1'b1, 1'b0, 1'b0, MEM_STATUS_ADDR, 1'b0, CHK_TABLE, 16'hFFFD, LAT_NOW},
	'{"st_rd_hi", 1'b1, 1'b0, 1'b0, MEM_STATUS_ADDR, 1'b1, CHK_TABLE, 16'hFFFF, LAT_NOW},
	'{"st_wr   ", 1'b0, 1'b1, 1'b0, MEM_STATUS_ADDR, 1'b0, CHK_LAST, 16'h0000, LAT_NOW},
	'{"b1_rd_01", 1'b1, 1'b0, 1'b0, 16'h8001, 1'b0, CHK_SHADOW, 16'h0000, LAT1},
	'{"b2_rd_01", 1'b1, 1'b0, 1'b0, 16'h0001, 1'b0, CHK_SHADOW, 16'h0000, LAT2},
	'{"hold_b2 ", 1'b0, 1'b0, 1'b0, 16'h0000, 1'b0, CHK_LAST, 16'h0000, LAT_NOW},
	// High address bits outside the bank are ignored
	'{"b2_alias", 1'b1, 1'b0, 1'b0, 16'h7F10, 1'b0, CHK_SHADOW, 16'h0000, LAT2},
	'{"hold_end", 1'b0, 1'b0, 1'b0, 16'h0000, 1'b1, CHK_LAST, 16'h0000, LAT_NOW}
};

`endif

/* sim/tb_mem_subsystem.sv */
`timescale 1ns/100ps

module tb_mem_subsystem import mem_pkg::*; ();

	localparam int RAM_ADDR_BITS = 8;
	localparam int RAM1_WAIT     = 2;
	localparam int RAM2_WAIT     = 0;
	localparam int LAT1          = RAM1_WAIT + 1;
	localparam int LAT2          = RAM2_WAIT + 1;
	localparam int LAT_NOW       = 0;
	localparam int TIMEOUT       = 20;
	localparam int BANK_WORDS    = 2 ** RAM_ADDR_BITS;
	localparam logic [31:0] SEED = 32'h922a_1c7c;

	// What a row compares feedback against
	localparam logic [1:0] CHK_NONE   = 2'd0;
	localparam logic [1:0] CHK_TABLE  = 2'd1;
	localparam logic [1:0] CHK_SHADOW = 2'd2;
	localparam logic [1:0] CHK_LAST   = 2'd3;

	typedef struct packed {
		logic [8*8-1:0] name;
		logic           rd;
		logic           wr;
		logic           init_wr;
		mem_addr_t      addr;
		logic           uart;
		logic [1:0]     chk;
		mem_word_t      exp_fb;
		int             exp_lat;
	} vec_t;

	`include "tb_vectors.svh"

	logic      clk;
	logic      rst_n;
	mem_req_t  req;
	logic      uart_received_data;
	logic      work_done;
	mem_word_t feedback;

	mem_word_t shadow1 [BANK_WORDS];
	mem_word_t shadow2 [BANK_WORDS];
	mem_word_t last_read;
	int        error_count;
	int        check_count;
	bit        timed_out;

	tb_clock_gen u_clock_gen (
		.clk   (clk),
		.rst_n (rst_n)
	);

	mem_subsystem #(
		.RAM_ADDR_BITS (RAM_ADDR_BITS),
		.RAM1_WAIT     (RAM1_WAIT),
		.RAM2_WAIT     (RAM2_WAIT)
	) i_mem_subsystem (
		.clk                (clk),
		.rst_n              (rst_n),
		.req                (req),
		.uart_received_data (uart_received_data),
		.work_done          (work_done),
		.feedback           (feedback)
	);

	//////////////////////////////
	// Reference model
	//////////////////////////////

	// 0 for the status address, else the bank number
	function automatic int decode_bank(mem_addr_t addr);
		if (addr == MEM_STATUS_ADDR) begin
			return 0;
		end
		return addr[15] ? 1 : 2;
	endfunction

	function automatic mem_word_t shadow_read(mem_addr_t addr);
		if (decode_bank(addr) == 1) begin
			return shadow1[addr[RAM_ADDR_BITS-1:0]];
		end
		return shadow2[addr[RAM_ADDR_BITS-1:0]];
	endfunction

	// Sampled at falling edges, latency counted in rising edges
	task automatic wait_for_done(output int lat, output bit ok);
		lat = 0;
		@(negedge clk);
		while (!work_done && lat < TIMEOUT) begin
			@(negedge clk);
			lat++;
		end
		ok = work_done;
	endtask

	//////////////////////////////
	// Stimulus and checks
	//////////////////////////////

	initial begin
		vec_t      v;
		mem_word_t wdata;
		mem_word_t expect_fb;
		int        lat;
		bit        ok;
		int        n;

		req                = '0;
		uart_received_data = 1'b0;
		error_count        = 0;
		check_count        = 0;
		timed_out          = 1'b0;
		last_read          = '0;
		void'($urandom(SEED));
		for (int a = 0; a < BANK_WORDS; a++) begin
			shadow1[a] = '0;
			shadow2[a] = '0;
		end

		n = 0;
		while (rst_n !== 1'b1 && n < TIMEOUT) begin
			@(posedge clk);
			n++;
		end
		if (rst_n !== 1'b1) begin
			$display("reset was never released");
			error_count++;
			timed_out = 1'b1;
		end

		for (int i = 0; i < NUM_VECTORS && !timed_out; i++) begin
			v     = VECTORS[i];
			wdata = mem_word_t'($urandom());
			@(posedge clk);
			#1;
			req.rd             = v.rd;
			req.wr             = v.wr;
			req.init_wr        = v.init_wr;
			req.addr           = v.addr;
			req.wdata          = wdata;
			uart_received_data = v.uart;

			wait_for_done(lat, ok);
			check_count++;
			assert (ok) else begin
				$display("work_done did not rise within %0d cycles in row %s", TIMEOUT, v.name);
				error_count++;
			end
			if (!ok) begin
				timed_out = 1'b1;
				break;
			end

			check_count++;
			assert (lat == v.exp_lat) else begin
				$display("[ERROR] %s latency expected %0d actual %0d", v.name, v.exp_lat, lat);
				error_count++;
			end

			case (v.chk)
				CHK_TABLE:  expect_fb = v.exp_fb;
				CHK_SHADOW: expect_fb = shadow_read(v.addr);
				default:    expect_fb = last_read;
			endcase
			if (v.chk != CHK_NONE) begin
				check_count++;
				assert (feedback == expect_fb) else begin
					$display("[ERROR] %s feedback expected %h actual %h",
						v.name, expect_fb, feedback);
					error_count++;
				end
			end

			// Writes to the status address leave the banks alone
			if ((v.wr || v.init_wr) && decode_bank(v.addr) == 1) begin
				shadow1[v.addr[RAM_ADDR_BITS-1:0]] = wdata;
			end else if ((v.wr || v.init_wr) && decode_bank(v.addr) == 2) begin
				shadow2[v.addr[RAM_ADDR_BITS-1:0]] = wdata;
			end
			if (v.rd) begin
				last_read = expect_fb;
			end

			@(posedge clk);
			#1;
			req = '0;
		end

		$display("checks run: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

/* cpu_mem.f */
+incdir+include
hw/mem_pkg.sv
hw/ram_port.sv
hw/ram_controller.sv
hw/mem_subsystem.sv
sim/tb_clock_gen.sv
sim/tb_mem_subsystem.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the memory subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
	-f cpu_mem.f \
	--top-module tb_mem_subsystem

./obj_dir/Vtb_mem_subsystem | tee sim.log

if grep -q "TEST FAIL" sim.log; then
	exit 1
fi

if ! grep -q "TEST PASS" sim.log; then
	echo "simulation ended without a result line"
	exit 1
fi
